//--- sim.f
source/uart_cfg_pkg.sv
source/echo_pkg.sv
source/uart_rx_decoder.sv
source/echo_frame_ctrl.sv
source/uart_tx_serializer.sv
source/uart_echo_top.sv
tests/tb_clock_gen.sv
tests/tb_uart_echo.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert --timescale 1ns/1ps
TOP       = tb_uart_echo
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_uart_echo.sv
//--------------------------------------------------
// testbench for the UART echo responder
// drives uart_rx at the package baud and decodes uart_tx
// every message waits out the full 1 ms quiet gap
//--------------------------------------------------
`timescale 1ns/1ps

module tb_uart_echo;

	localparam int bit_clks = int'(uart_cfg_pkg::clks_per_bit);
	localparam int gap_clks = echo_pkg::gap_clks;

	logic           sys_clk;
	logic           sys_rst_n;
	logic           uart_rx;
	logic           uart_tx;
	echo_pkg::len_t msg_len;

	logic [7:0]  sent_q[$];  // payload bytes the DUT should keep
	logic [7:0]  exp_q[$];
	logic [7:0]  reply_q[$]; // filled by the tx monitor
	logic [31:0] rng_state;
	int          err_cnt = 0;
	int          tmo_cnt = 0;

	tb_clock_gen u_clock_gen (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	uart_echo_top u_dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_rx   (uart_rx),
		.uart_tx   (uart_tx),
		.msg_len   (msg_len)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [7:0] random_byte();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	task automatic check_value(input int actual, input int expected, input string what);
		assert (actual == expected) else begin
			$display("FAIL @ %0t: %s is %0d (0x%0h), expected %0d (0x%0h)",
				$time, what, actual, actual, expected, expected);
			err_cnt++;
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge sys_clk);
	endtask

	// one bit time on the rx line from a falling clock edge
	task automatic drive_bit(input logic level);
		uart_rx = level;
		wait_cycles(bit_clks);
	endtask

	task automatic send_byte(input logic [7:0] value, input bit bad_stop);
		drive_bit(1'b0);
		for (int i = 0; i < uart_cfg_pkg::data_bits; i++)
			drive_bit(value[i]); // lsb first
		drive_bit(!bad_stop);
		if (bad_stop)
			drive_bit(1'b1); // line high again so the next start edge is seen
	endtask

	task automatic send_queue();
		foreach (sent_q[i])
			send_byte(sent_q[i], 1'b0);
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (sys_rst_n !== 1'b1 && waited < 20) begin
			@(negedge sys_clk);
			waited++;
		end
		if (sys_rst_n !== 1'b1) begin
			$display("timeout: reset was never released");
			tmo_cnt++;
		end
	endtask

	// reply must not start before the quiet gap has run out
	task automatic begin_reply();
		int waited;
		waited = 0;
		while (uart_tx !== 1'b0 && waited < gap_clks + 4 * bit_clks) begin
			@(negedge sys_clk);
			waited++;
		end
		if (uart_tx !== 1'b0) begin
			$display("timeout: no reply started within %0d clocks", waited);
			tmo_cnt++;
		end
		assert (waited >= gap_clks - bit_clks) else begin
			$display("FAIL @ %0t: reply started only %0d clocks after the last stop bit",
				$time, waited);
			err_cnt++;
		end
	endtask

	task automatic wait_reply_bytes(input int n);
		int waited;
		waited = 0;
		while (reply_q.size() < n && waited < (n + 1) * 11 * bit_clks) begin
			@(negedge sys_clk);
			waited++;
		end
		if (reply_q.size() < n) begin
			$display("timeout: only %0d of %0d reply bytes arrived", reply_q.size(), n);
			tmo_cnt++;
		end
	endtask

	// expected reply is markers, payload up to the limit, markers
	task automatic finish_reply(input string name);
		int exp_len;
		exp_q = {};
		exp_len = (sent_q.size() > echo_pkg::max_payload) ? echo_pkg::max_payload
			: sent_q.size();
		for (int i = 0; i < echo_pkg::marker_len; i++)
			exp_q.push_back(echo_pkg::marker_char);
		for (int i = 0; i < exp_len; i++)
			exp_q.push_back(sent_q[i]);
		for (int i = 0; i < echo_pkg::marker_len; i++)
			exp_q.push_back(echo_pkg::marker_char);
		wait_reply_bytes(exp_q.size());
		wait_cycles(3 * bit_clks); // let the line settle and the controller go idle
		check_value(reply_q.size(), exp_q.size(), {name, " reply length"});
		for (int i = 0; i < exp_q.size() && i < reply_q.size(); i++)
			check_value(int'(reply_q[i]), int'(exp_q[i]), $sformatf("%s byte %0d", name, i));
		check_value(int'(msg_len), exp_len, {name, " msg_len"});
		reply_q = {};
		sent_q = {};
	endtask

	task automatic expect_quiet(input int n);
		int low_cnt;
		low_cnt = 0;
		for (int i = 0; i < n; i++) begin
			@(negedge sys_clk);
			if (uart_tx !== 1'b1)
				low_cnt++;
		end
		check_value(low_cnt, 0, "clocks with uart_tx low on a quiet line");
		check_value(reply_q.size(), 0, "reply bytes on a quiet line");
	endtask

	// tx monitor samples each bit at its middle
	always begin : tx_monitor
		logic [7:0] data;
		@(negedge sys_clk);
		if (sys_rst_n === 1'b1 && uart_tx === 1'b0) begin
			wait_cycles(bit_clks / 2 - 1);
			check_value(int'(uart_tx), 0, "reply start bit");
			for (int i = 0; i < 8; i++) begin
				wait_cycles(bit_clks);
				data[i] = uart_tx;
			end
			for (int i = 0; i < 2; i++) begin
				wait_cycles(bit_clks);
				check_value(int'(uart_tx), 1, $sformatf("reply stop bit %0d", i));
			end
			reply_q.push_back(data);
		end
	end

	initial begin
		logic [7:0] bad_byte;
		uart_rx   = 1'b1;
		rng_state = 32'h028813a9;
		wait_reset_release();

		// idle after reset
		expect_quiet(gap_clks + 1000);
		check_value(int'(msg_len), 0, "msg_len after reset");

		sent_q.push_back(8'h41); // "A"
		send_queue();
		begin_reply();
		finish_reply("single byte");

		repeat (12) sent_q.push_back(random_byte());
		send_queue();
		begin_reply();
		finish_reply("burst of 12");

		repeat (70) sent_q.push_back(random_byte()); // 10 past the limit
		send_queue();
		begin_reply();
		finish_reply("burst of 70");

		// middle byte has a framing error
		sent_q.push_back(random_byte());
		sent_q.push_back(random_byte());
		bad_byte = random_byte();
		send_byte(sent_q[0], 1'b0);
		send_byte(bad_byte, 1'b1);
		send_byte(sent_q[1], 1'b0);
		begin_reply();
		finish_reply("bad stop bit");

		// extra byte arrives while the reply is on the line
		repeat (5) sent_q.push_back(random_byte());
		send_queue();
		begin_reply();
		wait_reply_bytes(1);
		send_byte(8'h5a, 1'b0);
		finish_reply("input during reply");
		expect_quiet(gap_clks + 2 * bit_clks);

		repeat (3) sent_q.push_back(random_byte());
		send_queue();
		begin_reply();
		finish_reply("after ignored byte");

		$display("checks done: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- tests/tb_clock_gen.sv
//--------------------------------------------------
// testbench clock, 20 ns period
// reset held low for the first 4 clock cycles
//--------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
	output logic sys_clk,
	output logic sys_rst_n
);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk; // half period
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1; // released away from the active edge
	end

endmodule

//--- source/uart_echo_top.sv
//--------------------------------------------------
// UART echo responder, rx pin in and tx pin out
// replies 1 ms after the last byte, framed by "&&"
//--------------------------------------------------
`timescale 1ns/1ps

module uart_echo_top (
	input  logic           sys_clk,
	input  logic           sys_rst_n,
	input  logic           uart_rx,
	output logic           uart_tx,
	output echo_pkg::len_t msg_len
);

	logic [7:0] rx_byte;
	logic       rx_valid;
	logic [7:0] tx_byte;
	logic       tx_start;
	logic       tx_done;

	uart_rx_decoder u_uart_rx_decoder (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

	echo_frame_ctrl u_echo_frame_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.tx_done   (tx_done),
		.tx_byte   (tx_byte),
		.tx_start  (tx_start),
		.msg_len   (msg_len)   // payload length of the last reply
	);

	uart_tx_serializer u_uart_tx_serializer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_byte   (tx_byte),
		.tx_start  (tx_start),
		.tx        (uart_tx),
		.tx_done   (tx_done)
	);

endmodule

//--- source/uart_tx_serializer.sv
//--------------------------------------------------
// UART transmitter, 1 start, 8 data, tx_stop_bits stop
// tx_start is ignored while a frame is in flight
//--------------------------------------------------
`timescale 1ns/1ps

module uart_tx_serializer (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       tx,
	output logic       tx_done
);

	typedef enum logic [1:0] {
		s_idle,
		s_start,
		s_data,
		s_stop
	} tx_state_t;

	tx_state_t state;

	logic [15:0] clk_cnt;
	logic [2:0]  bit_idx; // data bit, then reused for stop bits
	logic        bit_end;

	logic [uart_cfg_pkg::data_bits-1:0] shift_reg;

	assign bit_end = (clk_cnt == uart_cfg_pkg::clks_per_bit - 16'd1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= s_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx      <= 1'b1; // line idles high
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			case (state)
				s_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (tx_start) begin
						tx    <= 1'b0;
						state <= s_start;
					end
				end
				s_start: begin
					if (bit_end) begin
						clk_cnt <= '0;
						tx      <= shift_reg[0];
						state   <= s_data;
					end else begin
						clk_cnt <= clk_cnt + 16'd1;
					end
				end
				s_data: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == 3'(uart_cfg_pkg::data_bits - 1)) begin
							bit_idx <= '0;
							tx      <= 1'b1;
							state   <= s_stop;
						end else begin
							bit_idx <= bit_idx + 3'd1;
							tx      <= shift_reg[1]; // next bit, shift lands this cycle
						end
					end else begin
						clk_cnt <= clk_cnt + 16'd1;
					end
				end
				s_stop: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == 3'(uart_cfg_pkg::tx_stop_bits - 1)) begin
							tx_done <= 1'b1;
							state   <= s_idle;
						end else begin
							bit_idx <= bit_idx + 3'd1;
						end
					end else begin
						clk_cnt <= clk_cnt + 16'd1;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == s_idle && tx_start)
			shift_reg <= tx_byte;
		else if (state == s_data && bit_end)
			shift_reg <= shift_reg >> 1; // lsb first
	end

endmodule

//--- source/echo_frame_ctrl.sv
//--------------------------------------------------
// Collects bytes until the line is quiet for gap_clks
// then sends markers, payload, markers to the serializer
// input is ignored while a reply is going out
//--------------------------------------------------
`timescale 1ns/1ps

module echo_frame_ctrl (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic [7:0]        rx_byte,
	input  logic              rx_valid,
	input  logic              tx_done,
	output logic [7:0]        tx_byte,
	output logic              tx_start,
	output echo_pkg::len_t    msg_len
);

	echo_pkg::ctrl_state_t state;

	logic [7:0] msg_buf [echo_pkg::buf_depth];

	echo_pkg::len_t wr_idx; // next free entry, starts past the leading markers
	echo_pkg::len_t rd_idx;
	logic [15:0]    gap_cnt;

	logic [$clog2(echo_pkg::buf_depth)-1:0] wr_addr;
	logic [$clog2(echo_pkg::buf_depth)-1:0] rd_addr;

	logic       collecting;
	logic       accept;
	logic       store_en;
	logic       gap_expired;
	logic       send_next;
	logic [7:0] rd_data;

	assign collecting  = (state == echo_pkg::st_idle) || (state == echo_pkg::st_gap);
	assign accept      = collecting && rx_valid;
	// room left for payload, otherwise the byte is dropped
	assign store_en    = accept &&
		(wr_idx < echo_pkg::len_t'(echo_pkg::marker_len + echo_pkg::max_payload));
	assign gap_expired = (state == echo_pkg::st_gap) && !rx_valid &&
		(gap_cnt == 16'(echo_pkg::gap_clks - 1));
	assign send_next   = (state == echo_pkg::st_send) && tx_done;

	assign wr_addr = wr_idx[$clog2(echo_pkg::buf_depth)-1:0];
	assign rd_addr = rd_idx[$clog2(echo_pkg::buf_depth)-1:0];

	// entries 0 and 1 are the leading markers, taken from the constant
	assign rd_data = (rd_idx < echo_pkg::len_t'(echo_pkg::marker_len)) ?
		echo_pkg::marker_char : msg_buf[rd_addr];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= echo_pkg::st_idle;
			wr_idx   <= echo_pkg::len_t'(echo_pkg::marker_len);
			rd_idx   <= '0;
			gap_cnt  <= '0;
			tx_start <= 1'b0;
			msg_len  <= '0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				echo_pkg::st_idle: begin
					gap_cnt <= '0;
					if (accept) begin
						wr_idx <= wr_idx + 8'd1;
						state  <= echo_pkg::st_gap;
					end
				end
				echo_pkg::st_gap: begin
					if (accept) begin
						gap_cnt <= '0; // every strobe restarts the gap
						if (store_en)
							wr_idx <= wr_idx + 8'd1;
					end else if (gap_expired) begin
						gap_cnt  <= '0;
						wr_idx   <= wr_idx + echo_pkg::len_t'(echo_pkg::marker_len);
						msg_len  <= wr_idx - echo_pkg::len_t'(echo_pkg::marker_len);
						rd_idx   <= rd_idx + 8'd1;
						tx_start <= 1'b1; // first leading marker
						state    <= echo_pkg::st_send;
					end else begin
						gap_cnt <= gap_cnt + 16'd1;
					end
				end
				echo_pkg::st_send: begin
					if (send_next) begin
						rd_idx   <= rd_idx + 8'd1;
						tx_start <= 1'b1;
						if (rd_idx == wr_idx - 8'd1)
							state <= echo_pkg::st_done; // last entry handed over
					end
				end
				echo_pkg::st_done: begin
					// wait for the final byte to leave the line
					if (tx_done) begin
						wr_idx <= echo_pkg::len_t'(echo_pkg::marker_len);
						rd_idx <= '0;
						state  <= echo_pkg::st_idle;
					end
				end
				default: state <= echo_pkg::st_idle;
			endcase
		end
	end

	// message storage and outgoing byte
	always_ff @(posedge sys_clk) begin
		if (store_en) begin
			msg_buf[wr_addr] <= rx_byte;
		end else if (gap_expired) begin
			for (int i = 0; i < echo_pkg::marker_len; i++)
				msg_buf[wr_addr + i[$clog2(echo_pkg::buf_depth)-1:0]] <= echo_pkg::marker_char;
		end
		if (gap_expired || send_next)
			tx_byte <= rd_data; // steady when tx_start is seen
	end

endmodule

//--- source/uart_rx_decoder.sv
//--------------------------------------------------
// UART receiver, 8 data bits, no parity
// a frame with a low stop bit is dropped silently
// after such a frame the line must return high first
//--------------------------------------------------
`timescale 1ns/1ps

module uart_rx_decoder (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	typedef enum logic [1:0] {
		s_idle,
		s_start,
		s_data,
		s_stop
	} rx_state_t;

	rx_state_t state;

	logic rx_meta;
	logic rx_sync;
	logic rx_prev; // for falling edge detect
	logic fall_edge;

	logic [15:0] clk_cnt;
	logic [2:0]  bit_idx;
	logic        bit_end;
	logic        half_end;

	logic [uart_cfg_pkg::data_bits-1:0] shift_reg;

	// two flop synchronizer, line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall_edge = rx_prev & ~rx_sync;
	assign bit_end   = (clk_cnt == uart_cfg_pkg::clks_per_bit - 16'd1);
	assign half_end  = (clk_cnt == (uart_cfg_pkg::clks_per_bit >> 1) - 16'd1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= s_idle;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				s_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (fall_edge)
						state <= s_start;
				end
				s_start: begin
					if (half_end) begin
						clk_cnt <= '0;
						// still high at mid-bit means a glitch
						state <= rx_sync ? s_idle : s_data;
					end else begin
						clk_cnt <= clk_cnt + 16'd1;
					end
				end
				s_data: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'(uart_cfg_pkg::data_bits - 1))
							state <= s_stop;
					end else begin
						clk_cnt <= clk_cnt + 16'd1;
					end
				end
				s_stop: begin
					if (bit_end) begin
						clk_cnt  <= '0;
						rx_valid <= rx_sync; // framing error gives no strobe
						state    <= s_idle;
					end else begin
						clk_cnt <= clk_cnt + 16'd1;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// data path, sampled at mid-bit
	always_ff @(posedge sys_clk) begin
		if (state == s_data && bit_end)
			shift_reg <= {rx_sync, shift_reg[uart_cfg_pkg::data_bits-1:1]}; // lsb first
		if (state == s_stop && bit_end)
			rx_byte <= shift_reg;
	end

endmodule

//--- source/echo_pkg.sv
//--------------------------------------------------
// Echo framing constants and the controller FSM type
// payload is capped at buf_depth minus the four markers
//--------------------------------------------------
package echo_pkg;

	localparam logic [7:0] marker_char = 8'h26; // ascii "&"

	// markers on each side of the echoed payload
	localparam int marker_len = 2;

	localparam int buf_depth = 64; // entries incl. all markers

	// 60 bytes, anything past this is dropped
	localparam int max_payload = buf_depth - 2 * marker_len;

	// 1 ms of quiet line at 50 MHz ends a message
	localparam int gap_clks = 50_000;

	// payload length as reported on msg_len
	typedef logic [7:0] len_t;

	// idle -> gap (collecting) -> send -> done (last byte on the line)
	typedef enum logic [1:0] {
		st_idle,
		st_gap,
		st_send,
		st_done
	} ctrl_state_t;

endpackage

//--- source/uart_cfg_pkg.sv
//--------------------------------------------------
// UART line constants for the echo design
// fixed 50 MHz clock and 115200 baud, 8N2 on tx, 8N1 on rx
// baud is not selectable at runtime
//--------------------------------------------------
package uart_cfg_pkg;

	// system clock, must match the board oscillator
	localparam logic [31:0] clk_freq_hz = 32'd50_000_000;

	localparam logic [31:0] baud_rate = 32'd115_200; // line rate

	// clocks in one bit time, truncated, 434 at these rates
	// rate error stays well under 1% so no fractional divider
	localparam logic [15:0] clks_per_bit = 16'(clk_freq_hz / baud_rate);

	localparam int data_bits = 8; // lsb first on the wire

	// two stop bits on transmit give the far end some slack
	// receiver only checks the first one
	localparam int tx_stop_bits = 2;

endpackage
